// File: chan_defs.svh
`ifndef CHAN_DEFS_SVH
`define CHAN_DEFS_SVH

// adc sample as delivered, 12 data bits plus over-range in the lsb
`define CHAN_SAMPLE_W 13
`define CHAN_HALF_W 16      // one sign-extended sample
`define CHAN_WORD_W 32      // buffer and stream word, two samples

// circular buffer of 4096 words
`define CHAN_ADDR_W 12

`define CHAN_HDR_WORDS 3    // channel, trigger number, start address

// stream flow control
`define CHAN_CREDIT_MAX 8   // credits owned by the receiver after reset
`define CHAN_FIFO_DEPTH 16  // header fifo words

`endif

// File: chan_pkg.sv
`include "chan_defs.svh"

package chan_pkg;

  ////////////////////////////////////////////////////////////
  // plain vectors
  typedef logic [`CHAN_SAMPLE_W-1:0] sample_t;  // raw sample, ovr in bit 0
  typedef logic [`CHAN_WORD_W-1:0]   word_t;    // memory / stream word
  typedef logic [`CHAN_ADDR_W-1:0]   addr_t;    // buffer address or word count
  typedef logic [31:0]               trig_num_t;
  typedef logic [7:0]                chan_num_t;

  ////////////////////////////////////////////////////////////
  // grouped signals
  typedef struct packed {
    sample_t hi;  // goes to the upper half of the word
    sample_t lo;
  } adc_pair_t;

  // static while armed
  typedef struct packed {
    addr_t     buffer_size;       // words kept in the record
    addr_t     post_trig_size;    // words stored after the trigger word
    chan_num_t channel_num;
    trig_num_t initial_trig_num;  // first event number after reset
  } acq_cfg_t;

  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t data;
  } mem_wr_t;

  typedef struct packed {
    logic  valid;
    logic  last;  // final data word of a record
    word_t data;
  } stream_t;

  // acquisition controller states
  typedef enum logic [2:0] {IDLE, FILL, POST, HEADER, DONE} acq_state_t;

endpackage

// File: sample_packer.sv
`timescale 1ns/100ps
`include "chan_defs.svh"

module sample_packer import chan_pkg::*; (
  input  logic      adc_clk,
  input  logic      rst_n,
  input  adc_pair_t adc_pair,    // both samples of this adc cycle
  output word_t     packed_word  // registered, one cycle after adc_pair
);

  // copy the sample msb into the spare upper bits
  // the over-range flag stays in bit 0 of each half
  function automatic logic [`CHAN_HALF_W-1:0] sign_ext(input sample_t s);
    return {{(`CHAN_HALF_W - `CHAN_SAMPLE_W){s[`CHAN_SAMPLE_W-1]}}, s};
  endfunction

  logic [`CHAN_HALF_W-1:0] half_lo;  // low sample, low half
  logic [`CHAN_HALF_W-1:0] half_hi;

  always_comb begin
    half_lo = sign_ext(adc_pair.lo);
    half_hi = sign_ext(adc_pair.hi);
  end

  ////////////////////////////////////////////////////////////
  // output register, feeds the buffer write port
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      packed_word <= '0;
    end else begin
      packed_word <= {half_hi, half_lo};  // hi sample in [31:16]
    end
  end

endmodule

// File: sample_mem.sv
`timescale 1ns/100ps
`include "chan_defs.svh"

module sample_mem import chan_pkg::*; (
  input  logic    adc_clk,
  input  mem_wr_t mem_wr,   // write port, from the acquisition side
  input  addr_t   rd_addr,  // read port, from the readout side
  output word_t   rd_data   // valid one cycle after rd_addr
);

  localparam int DEPTH = 1 << `CHAN_ADDR_W;

  word_t ram [DEPTH];  // maps onto block ram

  always_ff @(posedge adc_clk) begin
    if (mem_wr.we) begin
      ram[mem_wr.addr] <= mem_wr.data;
    end
    rd_data <= ram[rd_addr];  // registered read, old data on collision
  end

endmodule

// File: header_fifo.sv
`timescale 1ns/100ps
`include "chan_defs.svh"

module header_fifo import chan_pkg::*; (
  input  logic  adc_clk,
  input  logic  rst_n,
  input  logic  hdr_we,
  input  word_t hdr_wdata,
  input  logic  hdr_re,     // pops the head word
  output word_t hdr_rdata,  // head word, valid while not empty
  output logic  hdr_full,
  output logic  hdr_empty
);

  localparam int PTR_W = $clog2(`CHAN_FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  word_t            fifo_ram [`CHAN_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;   // words held
  logic             do_wr;
  logic             do_rd;

  assign do_wr = hdr_we && !hdr_full;   // writes into a full fifo are dropped
  assign do_rd = hdr_re && !hdr_empty;

  assign hdr_full  = (count == CNT_W'(`CHAN_FIFO_DEPTH));
  assign hdr_empty = (count == '0);
  assign hdr_rdata = fifo_ram[rd_ptr];  // show-ahead

  always_ff @(posedge adc_clk) begin
    if (do_wr) begin
      fifo_ram[wr_ptr] <= hdr_wdata;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
    end
  end

endmodule

// File: acq_control.sv
`timescale 1ns/100ps
`include "chan_defs.svh"

module acq_control import chan_pkg::*; (
  input  logic     adc_clk,
  input  logic     rst_n,
  input  logic     acq_arm,      // async level from the master
  input  logic     acq_trig,     // async, rising edge starts the post-trigger count
  input  acq_cfg_t cfg,
  input  word_t    packed_word,  // from the packer
  output mem_wr_t  mem_wr,
  input  logic     hdr_full,
  output logic     hdr_we,
  output word_t    hdr_wdata,
  output logic     acq_done
);

  ////////////////////////////////////////////////////////////
  // two-stage synchronizers into adc_clk
  logic [1:0] arm_sync;
  logic [1:0] trig_sync;
  logic       trig_prev;   // for edge detect
  logic       arm;
  logic       trig_rise;

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      arm_sync  <= '0;
      trig_sync <= '0;
      trig_prev <= 1'b0;
    end else begin
      arm_sync  <= {arm_sync[0], acq_arm};
      trig_sync <= {trig_sync[0], acq_trig};
      trig_prev <= trig_sync[1];
    end
  end

  assign arm       = arm_sync[1];
  assign trig_rise = trig_sync[1] && !trig_prev;

  ////////////////////////////////////////////////////////////
  // acquisition fsm
  acq_state_t state;
  addr_t      wr_addr;    // next buffer slot, also the start address after capture
  addr_t      next_addr;
  addr_t      post_cnt;   // words stored after the trigger word
  logic [1:0] hdr_cnt;    // header word index
  trig_num_t  trig_num;
  logic       hdr_last;

  // wrap at buffer_size, not at the ram size
  assign next_addr = (wr_addr == cfg.buffer_size - 1'b1) ? '0 : wr_addr + 1'b1;
  assign hdr_last  = (hdr_cnt == 2'(`CHAN_HDR_WORDS - 1));

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      state    <= IDLE;
      wr_addr  <= '0;
      post_cnt <= '0;
      hdr_cnt  <= '0;
      trig_num <= cfg.initial_trig_num;  // event number starts here
    end else begin
      case (state)
        IDLE: begin
          wr_addr <= '0;
          if (arm) state <= FILL;
        end
        FILL: begin  // circular capture until the trigger
          wr_addr  <= next_addr;
          post_cnt <= '0;
          hdr_cnt  <= '0;
          if (!arm) begin
            state <= IDLE;  // disarmed before a trigger
          end else if (trig_rise) begin  // this cycle stores the trigger word
            state <= (cfg.post_trig_size == '0) ? HEADER : POST;
          end
        end
        POST: begin
          wr_addr  <= next_addr;
          post_cnt <= post_cnt + 1'b1;
          if (!arm) state <= IDLE;
          else if (post_cnt == cfg.post_trig_size - 1'b1) state <= HEADER;
        end
        HEADER: begin
          if (!hdr_full) begin  // stall while the fifo is full
            hdr_cnt <= hdr_cnt + 1'b1;
            if (hdr_last) state <= DONE;
          end
        end
        DONE: begin
          if (!arm) begin  // master saw done and released arm
            state    <= IDLE;
            trig_num <= trig_num + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // outputs, decoded from state
  always_comb begin
    mem_wr.we   = (state == FILL) || (state == POST);  // one word per cycle
    mem_wr.addr = wr_addr;
    mem_wr.data = packed_word;
  end

  assign hdr_we = (state == HEADER) && !hdr_full;

  always_comb begin
    case (hdr_cnt)
      2'd0:    hdr_wdata = word_t'(cfg.channel_num);
      2'd1:    hdr_wdata = trig_num;
      default: hdr_wdata = word_t'(wr_addr);  // oldest word of the record
    endcase
  end

  assign acq_done = (state == DONE);

endmodule

// File: readout_ctrl.sv
`timescale 1ns/100ps
`include "chan_defs.svh"

module readout_ctrl import chan_pkg::*; (
  input  logic     adc_clk,
  input  logic     rst_n,
  input  acq_cfg_t cfg,
  input  word_t    hdr_rdata,
  input  logic     hdr_empty,
  output logic     hdr_re,
  output addr_t    rd_addr,
  input  word_t    rd_data,     // one cycle after rd_addr
  input  logic     credit_ret,  // one credit back per cycle high
  output stream_t  stream_out
);

  typedef enum logic {RD_HDR, RD_DATA} rd_state_t;

  localparam int CRED_W = $clog2(`CHAN_CREDIT_MAX + 1);

  rd_state_t         state;
  logic [1:0]        hdr_cnt;
  logic              hdr_last;
  addr_t             rd_ptr;     // next buffer address to read
  addr_t             rd_left;    // reads still to issue for this record
  logic              rd_issue;
  logic              rd_vld;     // rd_data holds a word this cycle
  logic              rd_last;
  logic [1:0]        pend;       // reads in flight plus skid words, max 2
  logic [CRED_W-1:0] credits;    // words we may still send

  ////////////////////////////////////////////////////////////
  // two-entry skid, absorbs the read latency
  word_t      skid_data [2];
  logic [1:0] skid_last;
  logic [1:0] skid_wp;           // bit 1 is the wrap flag
  logic [1:0] skid_rp;
  logic       push;
  logic       pop;
  logic       out_vld;
  logic       out_last;
  word_t      out_data;

  assign hdr_last = (hdr_cnt == 2'(`CHAN_HDR_WORDS - 1));
  // header pops wait for a free slot and for the memory return slot
  assign hdr_re   = (state == RD_HDR) && !hdr_empty && (pend != 2'd2) && !rd_vld;
  assign rd_issue = (state == RD_DATA) && (pend != 2'd2);
  assign rd_addr  = rd_ptr;
  assign push     = hdr_re || rd_vld;
  assign pop      = (skid_wp != skid_rp) && (credits != '0);  // send only on credit

  always_ff @(posedge adc_clk) begin
    if (push) begin
      skid_data[skid_wp[0]] <= hdr_re ? hdr_rdata : rd_data;
      skid_last[skid_wp[0]] <= !hdr_re && rd_last;
    end
    if (pop) out_data <= skid_data[skid_rp[0]];
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      state    <= RD_HDR;
      hdr_cnt  <= '0;
      rd_ptr   <= '0;
      rd_left  <= '0;
      rd_vld   <= 1'b0;
      rd_last  <= 1'b0;
      pend     <= '0;
      credits  <= CRED_W'(`CHAN_CREDIT_MAX);
      skid_wp  <= '0;
      skid_rp  <= '0;
      out_vld  <= 1'b0;
      out_last <= 1'b0;
    end else begin
      rd_vld   <= rd_issue;
      rd_last  <= rd_issue && (rd_left == addr_t'(1));
      pend     <= pend + 2'(hdr_re || rd_issue) - 2'(pop);
      credits  <= credits + CRED_W'(credit_ret) - CRED_W'(pop);
      out_vld  <= pop;
      out_last <= pop && skid_last[skid_rp[0]];
      if (push) skid_wp <= skid_wp + 1'b1;
      if (pop)  skid_rp <= skid_rp + 1'b1;
      case (state)
        RD_HDR: if (hdr_re) begin
          hdr_cnt <= hdr_last ? '0 : hdr_cnt + 1'b1;
          if (hdr_last) begin  // third word is the start address
            rd_ptr  <= hdr_rdata[`CHAN_ADDR_W-1:0];
            rd_left <= cfg.buffer_size;
            state   <= RD_DATA;
          end
        end
        RD_DATA: if (rd_issue) begin
          rd_ptr  <= (rd_ptr == cfg.buffer_size - 1'b1) ? '0 : rd_ptr + 1'b1;
          rd_left <= rd_left - 1'b1;
          if (rd_left == addr_t'(1)) state <= RD_HDR;  // record fully read
        end
        default: state <= RD_HDR;
      endcase
    end
  end

  always_comb begin
    stream_out.valid = out_vld;
    stream_out.last  = out_last;
    stream_out.data  = out_data;
  end

endmodule

// File: channel_top.sv
`timescale 1ns/100ps

module channel_top import chan_pkg::*; (
  input  logic      adc_clk,
  input  logic      rst_n,
  input  logic      acq_arm,     // from master, async
  input  logic      acq_trig,    // from master, async
  input  acq_cfg_t  cfg,
  input  adc_pair_t adc_pair,
  output logic      acq_done,
  output stream_t   stream_out,
  input  logic      credit_ret
);

  ////////////////////////////////////////////////////////////
  // internal nets
  word_t   packed_word;
  mem_wr_t mem_wr;
  addr_t   rd_addr;
  word_t   rd_data;
  logic    hdr_we;
  word_t   hdr_wdata;
  logic    hdr_re;
  word_t   hdr_rdata;
  logic    hdr_full;
  logic    hdr_empty;

  sample_packer u_packer (
    .adc_clk     (adc_clk),
    .rst_n       (rst_n),
    .adc_pair    (adc_pair),
    .packed_word (packed_word)
  );

  acq_control u_acq (
    .adc_clk     (adc_clk),
    .rst_n       (rst_n),
    .acq_arm     (acq_arm),
    .acq_trig    (acq_trig),
    .cfg         (cfg),
    .packed_word (packed_word),
    .mem_wr      (mem_wr),       // to buffer port a
    .hdr_full    (hdr_full),
    .hdr_we      (hdr_we),
    .hdr_wdata   (hdr_wdata),
    .acq_done    (acq_done)
  );

  sample_mem u_mem (
    .adc_clk (adc_clk),
    .mem_wr  (mem_wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  header_fifo u_hdr_fifo (
    .adc_clk   (adc_clk),
    .rst_n     (rst_n),
    .hdr_we    (hdr_we),
    .hdr_wdata (hdr_wdata),
    .hdr_re    (hdr_re),
    .hdr_rdata (hdr_rdata),
    .hdr_full  (hdr_full),
    .hdr_empty (hdr_empty)
  );

  readout_ctrl u_readout (
    .adc_clk    (adc_clk),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .hdr_rdata  (hdr_rdata),
    .hdr_empty  (hdr_empty),
    .hdr_re     (hdr_re),
    .rd_addr    (rd_addr),      // buffer port b
    .rd_data    (rd_data),
    .credit_ret (credit_ret),
    .stream_out (stream_out)
  );

endmodule

// File: tb_ref.svh
////////////////////////////////////////////////////////////
// stimulus lfsr, 32-bit fibonacci, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // new bit enters at the lsb
endfunction

////////////////////////////////////////////////////////////
// expected values

// each 13-bit sample widened as a signed number, lo sample in the low half
function automatic word_t pack_ref(input adc_pair_t p);
  logic signed [15:0] lo16;
  logic signed [15:0] hi16;
  lo16 = 16'($signed(p.lo));  // signed cast, so the widening copies the sign
  hi16 = 16'($signed(p.hi));
  return {hi16, lo16};
endfunction

// header word 0 is the channel, word 1 the event number of record rec
function automatic word_t expected_header(input int idx, input acq_cfg_t c, input int rec);
  case (idx)
    0:       return word_t'(c.channel_num);
    default: return c.initial_trig_num + trig_num_t'(rec);
  endcase
endfunction

////////////////////////////////////////////////////////////
// failure handling

task automatic abort_run();
  $display("ERRORS FOUND");
  $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (expected !== actual) begin
    $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    abort_run();
  end
endtask

task automatic timed_out(input string what);
  $display("timeout while waiting for %s", what);
  abort_run();
endtask

// File: tb_channel.sv
`timescale 1ns/100ps
`include "chan_defs.svh"

module tb_channel import chan_pkg::*; ();

  localparam int BUF_WORDS  = 64;
  localparam int POST_WORDS = 20;
  localparam int LOG_DEPTH  = 4096;  // pairs remembered, far more than the run needs

  logic      adc_clk;
  logic      rst_n;
  logic      acq_arm;
  logic      acq_trig;
  acq_cfg_t  cfg;
  adc_pair_t adc_pair;
  logic      acq_done;
  stream_t   stream_out;
  logic      credit_ret;

  logic [31:0] lfsr;
  int          cyc;                   // edge count, also index of the pair driven there
  int          trig_edge;             // edge that first sampled acq_trig high
  logic        trig_last;
  adc_pair_t   pair_log [LOG_DEPTH];
  int          rcv_count;             // words taken from the stream
  int          ret_count;             // credits driven back
  int          ret_seen;              // credits returned, as seen by the monitor
  word_t       rx_data [$];
  logic        rx_last [$];

  `include "tb_ref.svh"

  channel_top u_dut (
    .adc_clk    (adc_clk),
    .rst_n      (rst_n),
    .acq_arm    (acq_arm),
    .acq_trig   (acq_trig),
    .cfg        (cfg),
    .adc_pair   (adc_pair),
    .acq_done   (acq_done),
    .stream_out (stream_out),
    .credit_ret (credit_ret)
  );

  initial begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;  // 100 ns period
  end

  task automatic draw_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b = lfsr[0];
  endtask

  // 11-bit signed ramp widened into the 12 data bits, over-range in bit 0
  function automatic adc_pair_t make_pair(input int n, input logic ovr_hi, input logic ovr_lo);
    logic [10:0] r_lo;
    logic [10:0] r_hi;
    adc_pair_t   p;
    r_lo = 11'(n * 13);        // steep ramp, crosses zero often
    r_hi = 11'(n * 13 + 700);
    p.lo = {r_lo[10], r_lo, ovr_lo};
    p.hi = {r_hi[10], r_hi, ovr_hi};
    return p;
  endfunction

  ////////////////////////////////////////////////////////////
  // adc ramp and credit return, both on the rising edge
  always @(posedge adc_clk) begin : drive_adc
    adc_pair_t p;
    logic      b_lo;
    logic      b_hi;
    logic      b_cr;
    draw_bit(b_lo);
    draw_bit(b_hi);
    draw_bit(b_cr);
    p = make_pair(cyc, b_hi, b_lo);
    adc_pair <= p;
    if (cyc < LOG_DEPTH) pair_log[cyc] = p;
    if (b_cr && (rcv_count > ret_count)) begin  // only credits the receiver holds
      credit_ret <= 1'b1;
      ret_count = ret_count + 1;
    end else begin
      credit_ret <= 1'b0;
    end
    if (acq_trig && !trig_last) trig_edge = cyc;  // old value, as the dut samples it
    trig_last = acq_trig;
    cyc = cyc + 1;
  end

  ////////////////////////////////////////////////////////////
  // stream monitor, samples mid-cycle
  always @(negedge adc_clk) begin : watch_stream
    if (rst_n && stream_out.valid) begin
      rcv_count = rcv_count + 1;
      check_value("credit limit", 32'd1, 32'(rcv_count <= `CHAN_CREDIT_MAX + ret_seen));
      rx_data.push_back(stream_out.data);
      rx_last.push_back(stream_out.last);
    end
    if (credit_ret) ret_seen = ret_seen + 1;
  end

  task automatic wait_done(input logic level, input int limit, output int n);
    n = 0;
    while (acq_done !== level) begin
      @(negedge adc_clk);
      n = n + 1;
      if (n > limit) timed_out("acq_done");
    end
  endtask

  task automatic wait_words(input int count, input int limit);
    int n;
    n = 0;
    while (rx_data.size() < count) begin
      @(negedge adc_clk);
      n = n + 1;
      if (n > limit) timed_out("stream words");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // one arm, trigger, readout and disarm
  task automatic run_record(input int rec);
    int    n;
    int    first_idx;
    string tag;
    tag = $sformatf("record %0d", rec);
    @(posedge adc_clk);
    acq_arm <= 1'b1;
    repeat (BUF_WORDS + 16) @(posedge adc_clk);  // whole buffer written first
    acq_trig <= 1'b1;
    wait_done(1'b1, 200, n);
    @(posedge adc_clk);
    acq_trig <= 1'b0;
    wait_words(`CHAN_HDR_WORDS + BUF_WORDS, 3000);
    // header
    check_value({tag, " channel"}, expected_header(0, cfg, rec), rx_data[0]);
    check_value({tag, " trigger number"}, expected_header(1, cfg, rec), rx_data[1]);
    check_value({tag, " start address range"}, 32'd1, 32'(rx_data[2] < BUF_WORDS));
    for (int i = 0; i < `CHAN_HDR_WORDS; i++) begin
      check_value({tag, " header last flag"}, 32'd0, 32'(rx_last[i]));
    end
    // record ends with the pair sampled POST_WORDS edges after the trigger word
    first_idx = trig_edge + POST_WORDS - BUF_WORDS + 1;
    for (int i = 0; i < BUF_WORDS; i++) begin
      check_value($sformatf("%s data word %0d", tag, i),
                  pack_ref(pair_log[first_idx + i]), rx_data[`CHAN_HDR_WORDS + i]);
      check_value($sformatf("%s last flag %0d", tag, i),
                  32'(i == BUF_WORDS - 1), 32'(rx_last[`CHAN_HDR_WORDS + i]));
    end
    @(posedge adc_clk);
    acq_arm <= 1'b0;
    wait_done(1'b0, 20, n);
    check_value({tag, " done fall delay"}, 32'd1, 32'((n >= 3) && (n <= 4)));
    @(posedge adc_clk);
    check_value({tag, " word count"}, 32'(`CHAN_HDR_WORDS + BUF_WORDS), 32'(rx_data.size()));
    rx_data.delete();
    rx_last.delete();
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  initial begin : run_test
    lfsr       = 32'hc458fa9b;
    cyc        = 0;
    trig_edge  = 0;
    trig_last  = 1'b0;
    rcv_count  = 0;
    ret_count  = 0;
    ret_seen   = 0;
    rst_n      = 1'b0;
    acq_arm    = 1'b0;
    acq_trig   = 1'b0;
    adc_pair   = '0;
    credit_ret = 1'b0;
    cfg.buffer_size      = addr_t'(BUF_WORDS);
    cfg.post_trig_size   = addr_t'(POST_WORDS);
    cfg.channel_num      = 8'h5a;
    cfg.initial_trig_num = 32'h0000_1230;
    repeat (2) @(posedge adc_clk);
    rst_n <= 1'b1;
    repeat (4) begin  // quiet after reset
      @(negedge adc_clk);
      check_value("done after reset", 32'd0, 32'(acq_done));
      check_value("valid after reset", 32'd0, 32'(stream_out.valid));
    end
    for (int rec = 0; rec < 2; rec++) begin
      run_record(rec);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: flist.f
+incdir+.
chan_pkg.sv
sample_packer.sv
sample_mem.sv
header_fifo.sv
acq_control.sv
readout_ctrl.sv
channel_top.sv
tb_channel.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing -Wno-fatal
TOP   = tb_channel
FLIST = flist.f
LOG   = sim.log
BIN   = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(wildcard *.sv) $(wildcard *.svh)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: compile
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
